// File: main_mem.f
design/main_mem_pkg.sv
design/lane_req_if.sv
design/req_decode.sv
design/thread_xbar.sv
design/bank_ram.sv
design/read_return.sv
design/mc_grant_timer.sv
design/main_mem.sv
tests/tb_main_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the main_mem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_main_mem -Mdir obj_dir -f main_mem.f; then
    echo "Verilator build did not complete"
    exit 1
fi

output="$(./obj_dir/Vtb_main_mem)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Regression passed$"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1

// File: tests/tb_main_mem.sv
`timescale 1ns/1ps

module tb_main_mem;
    import main_mem_pkg::*;

    localparam int NUM_RT = 4;
    localparam int NUM_THREAD = 8;
    localparam int ROW_W = 6;
    localparam int MC_WAIT = 64;
    localparam int WORDS = LANES * (2 ** ROW_W);
    // Strobe negedge to the negedge that sees rdy_RT
    localparam int RD_DELAY = 4;
    localparam int LIMIT = 200;
    localparam int RAND_CYCLES = 40;

    logic clk;
    logic rst_n;
    logic we_RT [NUM_RT-1:0];
    logic re_RT [NUM_RT-1:0];
    logic [ADDR_W-1:0] addr_RT [NUM_RT-1:0];
    logic [LINE_W-1:0] data_RT_in [NUM_RT-1:0];
    logic re_MC;
    logic [LINE_W-1:0] data_RT_out [NUM_RT-1:0];
    logic rdy_RT [NUM_RT-1:0];
    logic rdy_MC;

    // Reference memory with one word per thread and word index
    logic [LANE_W-1:0] model [NUM_THREAD][WORDS];
    // Outstanding reads as {port, line}
    logic [LINE_W+1:0] exp_q [$];
    logic [31:0] lfsr;
    int errors;
    int tests;

    main_mem #(
        .NUM_RT(NUM_RT),
        .NUM_THREAD(NUM_THREAD),
        .ROW_W(ROW_W),
        .MC_WAIT(MC_WAIT)
    ) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .we_RT(we_RT),
        .re_RT(re_RT),
        .addr_RT(addr_RT),
        .data_RT_in(data_RT_in),
        .re_MC(re_MC),
        .data_RT_out(data_RT_out),
        .rdy_RT(rdy_RT),
        .rdy_MC(rdy_MC)
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [LINE_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[LINE_W-2:0], lfsr[0]};
        end
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input int t, input int w);
        return (ADDR_W'(t) << THREAD_LSB) | (ADDR_W'(w) << WORD_LSB);
    endfunction

    function automatic logic [LANE_W-1:0] fill_word(input int t, input int w);
        return {8'h5a, 8'(t), 8'(w), 8'(w) ^ 8'(t * 37)};
    endfunction

    // Lane k of a line lives at word w+k wrapped inside the thread
    task automatic model_write(input int t, input int w, input logic [LINE_W-1:0] line);
        for (int k = 0; k < LANES; k++) begin
            model[t][(w + k) % WORDS] = line[k*LANE_W +: LANE_W];
        end
    endtask

    function automatic logic [LINE_W-1:0] model_line(input int t, input int w);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < LANES; k++) begin
            line[k*LANE_W +: LANE_W] = model[t][(w + k) % WORDS];
        end
        return line;
    endfunction

    task automatic clear_ports();
        for (int p = 0; p < NUM_RT; p++) begin
            we_RT[p] = 1'b0;
            re_RT[p] = 1'b0;
        end
    endtask

    task automatic start_cycle();
        @(negedge clk);
        clear_ports();
    endtask

    task automatic put_write(input int p, input int t, input int w,
                             input logic [LINE_W-1:0] line);
        we_RT[p] = 1'b1;
        addr_RT[p] = make_addr(t, w);
        data_RT_in[p] = line;
        model_write(t, w, line);
    endtask

    task automatic put_read(input int p, input int t, input int w);
        re_RT[p] = 1'b1;
        addr_RT[p] = make_addr(t, w);
    endtask

    task automatic check_line(input int p, input logic [LINE_W-1:0] expected);
        logic [LANE_W-1:0] e;
        logic [LANE_W-1:0] a;
        for (int k = 0; k < LANES; k++) begin
            e = expected[k*LANE_W +: LANE_W];
            a = data_RT_out[p][k*LANE_W +: LANE_W];
            if (a !== e) begin
                $display("Fail data_RT_out[%0d] lane %0d expected %h actual %h", p, k, e, a);
                errors++;
            end
        end
    endtask

    task automatic wait_read(input int p, input logic [LINE_W-1:0] expected);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < LIMIT) begin
            @(negedge clk);
            clear_ports();
            n++;
            seen = (rdy_RT[p] === 1'b1);
        end
        if (!seen) begin
            $display("Port %0d read got no ready within %0d cycles", p, LIMIT);
            errors++;
        end else begin
            if (n != RD_DELAY) begin
                $display("Fail rdy_RT[%0d] delay expected %h actual %h", p, RD_DELAY, n);
                errors++;
            end
            check_line(p, expected);
        end
    endtask

    task automatic read_check(input int p, input int t, input int w);
        start_cycle();
        put_read(p, t, w);
        wait_read(p, model_line(t, w));
    endtask

    task automatic check_returns();
        logic [LINE_W+1:0] head;
        for (int p = 0; p < NUM_RT; p++) begin
            if (rdy_RT[p] === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Port %0d raised ready with no read outstanding", p);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    if (head[LINE_W+1:LINE_W] != 2'(p)) begin
                        $display("Port %0d raised ready out of issue order", p);
                        errors++;
                    end else begin
                        check_line(p, head[LINE_W-1:0]);
                    end
                end
            end
        end
    endtask

    task automatic wait_mc(input int expected, input logic hold);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < LIMIT) begin
            @(negedge clk);
            if (!hold) begin
                re_MC = 1'b0;
            end
            n++;
            seen = (rdy_MC === 1'b1);
        end
        if (!seen) begin
            $display("rdy_MC did not pulse within %0d cycles", LIMIT);
            errors++;
        end else if (n != expected) begin
            $display("Fail rdy_MC delay expected %h actual %h", expected, n);
            errors++;
        end
    endtask

    task automatic check_mc_low();
        if (rdy_MC !== 1'b0) begin
            $display("Fail rdy_MC expected %h actual %h", 1'b0, rdy_MC);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    // Every word gets a known value with two threads per port
    task automatic fill_memory();
        logic [LINE_W-1:0] line;
        int t;
        int w;
        for (int s = 0; s < 2 * (WORDS / LANES); s++) begin
            start_cycle();
            for (int p = 0; p < NUM_RT; p++) begin
                t = p + NUM_RT * (s % 2);
                w = (s / 2) * LANES;
                for (int k = 0; k < LANES; k++) begin
                    line[k*LANE_W +: LANE_W] = fill_word(t, w + k);
                end
                put_write(p, t, w, line);
            end
        end
        start_cycle();
    endtask

    task automatic test_aligned();
        int err0;
        logic [LINE_W-1:0] line;
        err0 = errors;
        for (int p = 0; p < NUM_RT; p++) begin
            if (rdy_RT[p] !== 1'b0) begin
                $display("Fail rdy_RT[%0d] expected %h actual %h", p, 1'b0, rdy_RT[p]);
                errors++;
            end
        end
        check_mc_low();
        for (int p = 0; p < NUM_RT; p++) begin
            draw_bits(LINE_W, line);
            start_cycle();
            put_write(p, 2 * p, 4 * (p + 3), line);
            read_check(p, 2 * p, 4 * (p + 3));
        end
        report("Test 1 aligned write and read", err0);
    endtask

    task automatic test_unaligned();
        int err0;
        int w;
        logic [LINE_W-1:0] line;
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            // Offsets 1 to 3 and then the same offsets at the top of the thread
            w = (i < 3) ? 4 * 5 + i + 1 : WORDS - 3 + (i - 3);
            draw_bits(LINE_W, line);
            start_cycle();
            put_write(i % NUM_RT, 5, w, line);
            read_check((i + 1) % NUM_RT, 5, w);
            read_check(i % NUM_RT, 5, (w + 2) % WORDS);
        end
        report("Test 2 unaligned lines", err0);
    endtask

    task automatic test_concurrent();
        int err0;
        int base;
        int t;
        int w;
        logic [LINE_W-1:0] r;
        logic [LINE_W-1:0] line;
        err0 = errors;
        exp_q.delete();
        for (int c = 0; c < RAND_CYCLES || (exp_q.size() > 0 && c < RAND_CYCLES + LIMIT);
             c++) begin
            @(negedge clk);
            check_returns();
            clear_ports();
            if (c < RAND_CYCLES) begin
                draw_bits(3, r);
                base = int'(r[2:0]);
                for (int p = 0; p < NUM_RT; p++) begin
                    // Consecutive threads keep the ports apart
                    t = (base + p) % NUM_THREAD;
                    draw_bits(8, r);
                    w = int'(r[7:0]) % WORDS;
                    draw_bits(1, r);
                    if (r[0]) begin
                        draw_bits(LINE_W, line);
                        put_write(p, t, w, line);
                    end else begin
                        put_read(p, t, w);
                        exp_q.push_back({2'(p), model_line(t, w)});
                    end
                end
            end
        end
        if (exp_q.size() != 0) begin
            $display("%0d reads never saw a ready", exp_q.size());
            errors++;
        end
        report("Test 3 concurrent random traffic", err0);
    endtask

    task automatic test_collision();
        int err0;
        logic [LINE_W-1:0] low;
        logic [LINE_W-1:0] high;
        logic [LINE_W-1:0] line;
        err0 = errors;
        draw_bits(LINE_W, low);
        draw_bits(LINE_W, high);
        start_cycle();
        put_write(1, 6, 40, low);
        // Port 2 loses thread 6, so the model never sees it
        we_RT[2] = 1'b1;
        addr_RT[2] = make_addr(6, 42);
        data_RT_in[2] = high;
        read_check(3, 6, 40);
        read_check(3, 6, 42);
        draw_bits(LINE_W, line);
        start_cycle();
        put_write(0, 7, 77, line);
        start_cycle();
        put_read(0, 7, 77);
        wait_read(0, model_line(7, 77));
        report("Test 4 port collision and write then read", err0);
    endtask

    task automatic test_mc_timer();
        int err0;
        err0 = errors;
        @(negedge clk);
        re_MC = 1'b1;
        wait_mc(MC_WAIT, 1'b0);
        @(negedge clk);
        check_mc_low();
        re_MC = 1'b1;
        wait_mc(MC_WAIT, 1'b1);
        @(negedge clk);
        check_mc_low();
        re_MC = 1'b0;
        // Restart was sampled on the edge that ended the pulse
        wait_mc(MC_WAIT - 1, 1'b0);
        @(negedge clk);
        check_mc_low();
        report("Test 5 memory controller timer", err0);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        re_MC = 1'b0;
        lfsr = 32'd83840;
        errors = 0;
        tests = 0;
        for (int p = 0; p < NUM_RT; p++) begin
            we_RT[p] = 1'b0;
            re_RT[p] = 1'b0;
            addr_RT[p] = '0;
            data_RT_in[p] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_aligned();
        fill_memory();
        test_unaligned();
        test_concurrent();
        test_collision();
        test_mc_timer();

        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: design/main_mem.sv
`timescale 1ns/1ps

module main_mem #(
    parameter int NUM_RT = 4,
    parameter int NUM_THREAD = 8,
    parameter int ROW_W = 6,
    parameter int MC_WAIT = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we_RT [NUM_RT-1:0],
    input  logic                            re_RT [NUM_RT-1:0],
    input  logic [main_mem_pkg::ADDR_W-1:0] addr_RT [NUM_RT-1:0],
    input  logic [main_mem_pkg::LINE_W-1:0] data_RT_in [NUM_RT-1:0],
    input  logic                            re_MC,
    output logic [main_mem_pkg::LINE_W-1:0] data_RT_out [NUM_RT-1:0],
    output logic                            rdy_RT [NUM_RT-1:0],
    output logic                            rdy_MC
);
    import main_mem_pkg::*;

    logic bank_we [NUM_THREAD-1:0];
    logic [ROW_W-1:0] bank_row [NUM_THREAD-1:0][LANES-1:0];
    logic [LANE_W-1:0] bank_wdata [NUM_THREAD-1:0][LANES-1:0];
    logic [LANE_W-1:0] bank_q [NUM_THREAD-1:0][LANES-1:0];

    lane_req_if #(.NUM_THREAD(NUM_THREAD), .ROW_W(ROW_W)) req_if [NUM_RT] ();

    for (genvar p = 0; p < NUM_RT; p++) begin : g_dec
        req_decode #(.NUM_THREAD(NUM_THREAD), .ROW_W(ROW_W)) u_dec (
            .clk(clk),
            .rst_n(rst_n),
            .we(we_RT[p]),
            .re(re_RT[p]),
            .addr(addr_RT[p]),
            .wdata(data_RT_in[p]),
            .req(req_if[p])
        );
    end

    thread_xbar #(.NUM_RT(NUM_RT), .NUM_THREAD(NUM_THREAD), .ROW_W(ROW_W)) u_xbar (
        .clk(clk),
        .rst_n(rst_n),
        .reqs(req_if),
        .bank_we(bank_we),
        .bank_row(bank_row),
        .bank_wdata(bank_wdata)
    );

    // Four banks per thread share one write enable
    for (genvar t = 0; t < NUM_THREAD; t++) begin : g_thread
        for (genvar b = 0; b < LANES; b++) begin : g_bank
            bank_ram #(.ROW_W(ROW_W)) u_ram (
                .clk(clk),
                .we(bank_we[t]),
                .row(bank_row[t][b]),
                .wdata(bank_wdata[t][b]),
                .q(bank_q[t][b])
            );
        end
    end

    read_return #(.NUM_RT(NUM_RT), .NUM_THREAD(NUM_THREAD)) u_ret (
        .clk(clk),
        .rst_n(rst_n),
        .re(re_RT),
        .reqs(req_if),
        .bank_q(bank_q),
        .data_RT_out(data_RT_out),
        .rdy_RT(rdy_RT)
    );

    mc_grant_timer #(.MC_WAIT(MC_WAIT)) u_mc (
        .clk(clk),
        .rst_n(rst_n),
        .re_MC(re_MC),
        .rdy_MC(rdy_MC)
    );

endmodule

// File: design/mc_grant_timer.sv
`timescale 1ns/1ps

module mc_grant_timer #(
    parameter int MC_WAIT = 64
) (
    input  logic clk,
    input  logic rst_n,
    input  logic re_MC,
    output logic rdy_MC
);
    localparam int CNT_W = $clog2(MC_WAIT + 1);
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_COUNT = 1'b1;

    logic state;
    logic [CNT_W-1:0] cnt;
    logic done;

    // Count starts at 1 on the sampling edge
    assign done = (state == ST_COUNT) && (cnt == CNT_W'(MC_WAIT));
    assign rdy_MC = done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (re_MC) begin
                        state <= ST_COUNT;
                        cnt <= CNT_W'(1);
                    end
                end
                default: begin
                    if (!done) begin
                        cnt <= cnt + CNT_W'(1);
                    end else if (re_MC) begin
                        // The edge ending the pulse acts as idle
                        cnt <= CNT_W'(1);
                    end else begin
                        state <= ST_IDLE;
                        cnt <= '0;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/read_return.sv
`timescale 1ns/1ps

module read_return #(
    parameter int NUM_RT = 4,
    parameter int NUM_THREAD = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            re [NUM_RT-1:0],
    lane_req_if.ret                         reqs [NUM_RT],
    input  logic [main_mem_pkg::LANE_W-1:0] bank_q [NUM_THREAD-1:0][main_mem_pkg::LANES-1:0],
    output logic [main_mem_pkg::LINE_W-1:0] data_RT_out [NUM_RT-1:0],
    output logic                            rdy_RT [NUM_RT-1:0]
);
    import main_mem_pkg::*;

    localparam int TID_W = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1;

    for (genvar p = 0; p < NUM_RT; p++) begin : g_port
        logic rdy_s0, rdy_s1, rdy_s2;
        logic rd_d1, rd_d2;
        logic [TID_W-1:0] thread_d1, thread_d2;
        logic [LANE_ID_W-1:0] rot_d1, rot_d2, rot_d3;
        logic [LANE_W-1:0] line_q [LANES];

        // Ready follows every strobe including one to an unknown thread
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rdy_s0 <= 1'b0;
                rdy_s1 <= 1'b0;
                rdy_s2 <= 1'b0;
                rdy_RT[p] <= 1'b0;
                rd_d1 <= 1'b0;
                rd_d2 <= 1'b0;
                thread_d1 <= '0;
                thread_d2 <= '0;
                rot_d1 <= '0;
                rot_d2 <= '0;
                rot_d3 <= '0;
            end else begin
                rdy_s0 <= re[p];
                rdy_s1 <= rdy_s0;
                rdy_s2 <= rdy_s1;
                rdy_RT[p] <= rdy_s2;
                rd_d1 <= reqs[p].re;
                rd_d2 <= rd_d1;
                thread_d1 <= reqs[p].thread;
                thread_d2 <= thread_d1;
                rot_d1 <= reqs[p].rot;
                rot_d2 <= rot_d1;
                rot_d3 <= rot_d2;
            end
        end

        // Stage 3 gather
        always_ff @(posedge clk) begin
            if (rd_d2) begin
                for (int k = 0; k < LANES; k++) begin
                    line_q[k] <= bank_q[thread_d2][k];
                end
            end
        end

        for (genvar k = 0; k < LANES; k++) begin : g_lane
            logic [LANE_ID_W-1:0] src;

            assign src = rot_d3 + LANE_ID_W'(k);
            assign data_RT_out[p][k*LANE_W +: LANE_W] = line_q[src];
        end
    end

endmodule

// File: design/bank_ram.sv
`timescale 1ns/1ps

module bank_ram #(
    parameter int ROW_W = 6
) (
    input  logic                            clk,
    input  logic                            we,
    input  logic [ROW_W-1:0]                row,
    input  logic [main_mem_pkg::LANE_W-1:0] wdata,
    output logic [main_mem_pkg::LANE_W-1:0] q
);
    import main_mem_pkg::*;

    logic [LANE_W-1:0] mem [2**ROW_W];

    // Read first so q shows the old word on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[row] <= wdata;
        end
        q <= mem[row];
    end

endmodule

// File: design/thread_xbar.sv
`timescale 1ns/1ps

module thread_xbar #(
    parameter int NUM_RT = 4,
    parameter int NUM_THREAD = 8,
    parameter int ROW_W = 6
) (
    input  logic                            clk,
    input  logic                            rst_n,
    lane_req_if.xbar                        reqs [NUM_RT],
    output logic                            bank_we [NUM_THREAD-1:0],
    output logic [ROW_W-1:0]                bank_row [NUM_THREAD-1:0][main_mem_pkg::LANES-1:0],
    output logic [main_mem_pkg::LANE_W-1:0] bank_wdata [NUM_THREAD-1:0][main_mem_pkg::LANES-1:0]
);
    import main_mem_pkg::*;

    localparam int TID_W = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1;
    localparam int PID_W = (NUM_RT > 1) ? $clog2(NUM_RT) : 1;

    logic p_valid [NUM_RT];
    logic p_we [NUM_RT];
    logic [TID_W-1:0] p_thread [NUM_RT];
    logic [LANES-1:0][ROW_W-1:0] p_rows [NUM_RT];
    logic [LANES-1:0][LANE_W-1:0] p_wdata [NUM_RT];

    for (genvar p = 0; p < NUM_RT; p++) begin : g_port
        assign p_valid[p] = reqs[p].we | reqs[p].re;
        assign p_we[p] = reqs[p].we;
        assign p_thread[p] = reqs[p].thread;
        assign p_rows[p] = reqs[p].rows;
        assign p_wdata[p] = reqs[p].wdata;
    end

    for (genvar t = 0; t < NUM_THREAD; t++) begin : g_thread
        logic hit;
        logic [PID_W-1:0] sel;

        // Scan from the top so the lowest port is kept
        always_comb begin
            hit = 1'b0;
            sel = '0;
            for (int p = NUM_RT - 1; p >= 0; p--) begin
                if (p_valid[p] && (p_thread[p] == TID_W'(t))) begin
                    hit = 1'b1;
                    sel = PID_W'(p);
                end
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                bank_we[t] <= 1'b0;
            end else begin
                bank_we[t] <= hit & p_we[sel];
            end
        end

        // Idle threads hold their last rows
        always_ff @(posedge clk) begin
            if (hit) begin
                for (int k = 0; k < LANES; k++) begin
                    bank_row[t][k] <= p_rows[sel][k];
                    bank_wdata[t][k] <= p_wdata[sel][k];
                end
            end
        end
    end

endmodule

// File: design/req_decode.sv
`timescale 1ns/1ps

module req_decode #(
    parameter int NUM_THREAD = 8,
    parameter int ROW_W = 6
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  logic                            re,
    input  logic [main_mem_pkg::ADDR_W-1:0] addr,
    input  logic [main_mem_pkg::LINE_W-1:0] wdata,
    lane_req_if.decoder                     req
);
    import main_mem_pkg::*;

    localparam int TID_W = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1;
    // Word index within one thread with bank bits at the bottom
    localparam int WIDX_W = ROW_W + LANE_ID_W;

    logic [WIDX_W-1:0] widx;
    logic [LANE_ID_W-1:0] rot;
    logic [ADDR_W-THREAD_LSB-1:0] tid_full;
    logic in_range;
    logic [LANES-1:0][ROW_W-1:0] rows_next;
    logic [LANES-1:0][LANE_W-1:0] wdata_next;

    assign widx = addr[WORD_LSB +: WIDX_W];
    assign rot = widx[LANE_ID_W-1:0];
    assign tid_full = addr[ADDR_W-1:THREAD_LSB];
    assign in_range = (tid_full < NUM_THREAD);

    // Bank b holds the line lane that lands on it after rotation
    for (genvar b = 0; b < LANES; b++) begin : g_bank
        logic [LANE_ID_W-1:0] lane;
        logic [WIDX_W-1:0] word;

        assign lane = LANE_ID_W'(b) - rot;
        // Wraps inside the thread's word space
        assign word = widx + WIDX_W'(lane);
        assign rows_next[b] = word[WIDX_W-1:LANE_ID_W];
        assign wdata_next[b] = wdata[lane*LANE_W +: LANE_W];
    end

    // Stage 0 control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.we <= 1'b0;
            req.re <= 1'b0;
            req.thread <= '0;
            req.rot <= '0;
        end else begin
            // Unknown threads never reach a bank
            req.we <= we & in_range;
            req.re <= re & in_range;
            req.thread <= addr[THREAD_LSB +: TID_W];
            req.rot <= rot;
        end
    end

    // Stage 0 payload
    always_ff @(posedge clk) begin
        req.rows <= rows_next;
        req.wdata <= wdata_next;
    end

endmodule

// File: design/lane_req_if.sv
`timescale 1ns/1ps

interface lane_req_if #(
    parameter int NUM_THREAD = 8,
    parameter int ROW_W = 6
) ();
    import main_mem_pkg::*;

    localparam int TID_W = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1;

    // Stage 0 request already split per bank
    logic we;
    logic re;
    logic [TID_W-1:0] thread;
    // Word index modulo 4
    logic [LANE_ID_W-1:0] rot;
    // Indexed by bank rather than by lane
    logic [LANES-1:0][ROW_W-1:0] rows;
    logic [LANES-1:0][LANE_W-1:0] wdata;

    modport decoder (
        output we,
        output re,
        output thread,
        output rot,
        output rows,
        output wdata
    );

    modport xbar (
        input we,
        input re,
        input thread,
        input rows,
        input wdata
    );

    modport ret (
        input re,
        input thread,
        input rot
    );

endinterface

// File: design/main_mem_pkg.sv
package main_mem_pkg;

    // One request line is split across the four banks of a thread
    localparam int LANES = 4;

    // Width of a single bank word
    localparam int LANE_W = 32;

    // Width of a full request line
    localparam int LINE_W = LANES * LANE_W;

    // Bank index and rotation amount
    localparam int LANE_ID_W = 2;

    // Address field positions
    // bits 1:0 are byte offsets and are ignored
    localparam int WORD_LSB = 2;

    localparam int THREAD_LSB = 16;

    localparam int ADDR_W = 32;

endpackage
